// ==== axil_config.svh ====
`ifndef AXIL_CONFIG_SVH
`define AXIL_CONFIG_SVH

// Byte address width of every AXI4-Lite address channel.
`define AXIL_ADDR_WIDTH 12

// Data width on W and R.
// One strobe bit per byte follows from it.
`define AXIL_DATA_WIDTH 32

// Number of 32-bit words in the register bank.
// Addresses at or above four times this value answer SLVERR.
`define AXIL_REG_COUNT 16

`endif

// ==== axil_pkg.sv ====
package axil_pkg;

`include "axil_config.svh"

  // Byte address carried on AW, AR and the command port.
  typedef logic [`AXIL_ADDR_WIDTH-1:0] addr_t;

  // Data word carried on W, R and the command and response ports.
  typedef logic [`AXIL_DATA_WIDTH-1:0] data_t;

  // Byte strobe, one bit per data byte.
  typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t;

  // AXI response code on B and R.
  typedef logic [1:0] resp_t;

  // Only OKAY and SLVERR are ever produced.
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // States of the command master.
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WAIT_B,
    READ,
    WAIT_R,
    RESP
  } master_state_e;

endpackage

// ==== axil_spill_register.sv ====
`timescale 1ns/10ps

module axil_spill_register #(
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Slot A drives the output, slot B holds the beat caught during a stall.
  logic             a_full_q, a_full_d;
  logic             b_full_q, b_full_d;
  logic [WIDTH-1:0] a_data_q, b_data_q;
  logic             in_fire, out_fire;
  logic             a_from_b, a_from_in, b_load;

  // Ready looks only at slot B, so ready_i never reaches ready_o.
  assign ready_o  = ~b_full_q;
  assign valid_o  = a_full_q;
  assign data_o   = a_data_q;

  assign in_fire  = valid_i & ready_o;
  assign out_fire = a_full_q & ready_i;

  // Slot A refills from B first, to keep beat order.
  assign a_from_b  = out_fire & b_full_q;
  // Input goes straight to A when A is empty or drains this cycle.
  assign a_from_in = in_fire & (~a_full_q | out_fire);
  // Input spills into B when A is full and stalled.
  assign b_load    = in_fire & a_full_q & ~out_fire;

  assign a_full_d = a_from_b | a_from_in | (a_full_q & ~out_fire);
  assign b_full_d = b_load | (b_full_q & ~out_fire);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
    end
  end

  // Payload slots.
  always_ff @(posedge clk_i) begin
    if (a_from_b) begin
      a_data_q <= b_data_q;
    end else if (a_from_in) begin
      a_data_q <= data_i;
    end
    if (b_load) begin
      b_data_q <= data_i;
    end
  end

endmodule

// ==== axil_slice.sv ====
`timescale 1ns/10ps

module axil_slice
  import axil_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Slave side, facing the master.
  input  logic  s_aw_valid_i,
  output logic  s_aw_ready_o,
  input  addr_t s_aw_addr_i,
  input  logic  s_w_valid_i,
  output logic  s_w_ready_o,
  input  data_t s_w_data_i,
  input  strb_t s_w_strb_i,
  output logic  s_b_valid_o,
  input  logic  s_b_ready_i,
  output resp_t s_b_resp_o,
  input  logic  s_ar_valid_i,
  output logic  s_ar_ready_o,
  input  addr_t s_ar_addr_i,
  output logic  s_r_valid_o,
  input  logic  s_r_ready_i,
  output data_t s_r_data_o,
  output resp_t s_r_resp_o,
  // Master side, facing the slave.
  output logic  m_aw_valid_o,
  input  logic  m_aw_ready_i,
  output addr_t m_aw_addr_o,
  output logic  m_w_valid_o,
  input  logic  m_w_ready_i,
  output data_t m_w_data_o,
  output strb_t m_w_strb_o,
  input  logic  m_b_valid_i,
  output logic  m_b_ready_o,
  input  resp_t m_b_resp_i,
  output logic  m_ar_valid_o,
  input  logic  m_ar_ready_i,
  output addr_t m_ar_addr_o,
  input  logic  m_r_valid_i,
  output logic  m_r_ready_o,
  input  data_t m_r_data_i,
  input  resp_t m_r_resp_i
);

  // Packed channel widths.
  localparam int AX_WIDTH = $bits(addr_t);
  localparam int W_WIDTH  = $bits(data_t) + $bits(strb_t);
  localparam int B_WIDTH  = $bits(resp_t);
  localparam int R_WIDTH  = $bits(data_t) + $bits(resp_t);

  // W and R carry two fields each and travel as one vector.
  logic [W_WIDTH-1:0] w_in, w_out;
  logic [R_WIDTH-1:0] r_in, r_out;

  assign w_in = {s_w_data_i, s_w_strb_i};
  assign {m_w_data_o, m_w_strb_o} = w_out;
  // R flows from the master side back to the slave side.
  assign r_in = {m_r_data_i, m_r_resp_i};
  assign {s_r_data_o, s_r_resp_o} = r_out;

  // Write address, forward.
  axil_spill_register #(.WIDTH(AX_WIDTH)) i_spill_aw (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s_aw_valid_i),
    .ready_o (s_aw_ready_o),
    .data_i  (s_aw_addr_i),
    .valid_o (m_aw_valid_o),
    .ready_i (m_aw_ready_i),
    .data_o  (m_aw_addr_o)
  );

  // Write data, forward.
  axil_spill_register #(.WIDTH(W_WIDTH)) i_spill_w (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s_w_valid_i),
    .ready_o (s_w_ready_o),
    .data_i  (w_in),
    .valid_o (m_w_valid_o),
    .ready_i (m_w_ready_i),
    .data_o  (w_out)
  );

  // Write response, reverse.
  axil_spill_register #(.WIDTH(B_WIDTH)) i_spill_b (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (m_b_valid_i),
    .ready_o (m_b_ready_o),
    .data_i  (m_b_resp_i),
    .valid_o (s_b_valid_o),
    .ready_i (s_b_ready_i),
    .data_o  (s_b_resp_o)
  );

  // Read address, forward.
  axil_spill_register #(.WIDTH(AX_WIDTH)) i_spill_ar (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s_ar_valid_i),
    .ready_o (s_ar_ready_o),
    .data_i  (s_ar_addr_i),
    .valid_o (m_ar_valid_o),
    .ready_i (m_ar_ready_i),
    .data_o  (m_ar_addr_o)
  );

  // Read data, reverse.
  axil_spill_register #(.WIDTH(R_WIDTH)) i_spill_r (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (m_r_valid_i),
    .ready_o (m_r_ready_o),
    .data_i  (r_in),
    .valid_o (s_r_valid_o),
    .ready_i (s_r_ready_i),
    .data_o  (r_out)
  );

endmodule

// ==== axil_cmd_master.sv ====
`timescale 1ns/10ps

module axil_cmd_master
  import axil_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Command port.
  input  logic  cmd_valid_i,
  output logic  cmd_ready_o,
  input  logic  cmd_write_i,
  input  addr_t cmd_addr_i,
  input  data_t cmd_wdata_i,
  input  strb_t cmd_wstrb_i,
  // Response port.
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output resp_t rsp_resp_o,
  // AXI4-Lite master channels.
  output logic  m_aw_valid_o,
  input  logic  m_aw_ready_i,
  output addr_t m_aw_addr_o,
  output logic  m_w_valid_o,
  input  logic  m_w_ready_i,
  output data_t m_w_data_o,
  output strb_t m_w_strb_o,
  input  logic  m_b_valid_i,
  output logic  m_b_ready_o,
  input  resp_t m_b_resp_i,
  output logic  m_ar_valid_o,
  input  logic  m_ar_ready_i,
  output addr_t m_ar_addr_o,
  input  logic  m_r_valid_i,
  output logic  m_r_ready_o,
  input  data_t m_r_data_i,
  input  resp_t m_r_resp_i
);

  master_state_e state_q, state_d;
  logic          aw_done_q, aw_done_d;
  logic          w_done_q, w_done_d;
  logic          cmd_fire, b_fire, r_fire;
  addr_t         addr_q;
  data_t         wdata_q, rdata_q;
  strb_t         wstrb_q;
  resp_t         resp_q;

  // Handshake decodes, all from the registered state.
  assign cmd_ready_o  = (state_q == IDLE);
  assign m_aw_valid_o = (state_q == WRITE) && !aw_done_q;
  assign m_w_valid_o  = (state_q == WRITE) && !w_done_q;
  assign m_b_ready_o  = (state_q == WAIT_B);
  assign m_ar_valid_o = (state_q == READ);
  assign m_r_ready_o  = (state_q == WAIT_R);
  assign rsp_valid_o  = (state_q == RESP);

  assign cmd_fire = cmd_valid_i & cmd_ready_o;
  assign b_fire   = m_b_valid_i & m_b_ready_o;
  assign r_fire   = m_r_valid_i & m_r_ready_o;

  // Both address channels share the latched command address.
  assign m_aw_addr_o = addr_q;
  assign m_ar_addr_o = addr_q;
  assign m_w_data_o  = wdata_q;
  assign m_w_strb_o  = wstrb_q;
  assign rsp_rdata_o = rdata_q;
  assign rsp_resp_o  = resp_q;

  always_comb begin
    state_d   = state_q;
    aw_done_d = aw_done_q;
    w_done_d  = w_done_q;
    unique case (state_q)
      IDLE: begin
        aw_done_d = 1'b0;
        w_done_d  = 1'b0;
        if (cmd_valid_i) begin
          state_d = cmd_write_i ? WRITE : READ;
        end
      end
      WRITE: begin
        // AW and W may complete in either order.
        if (m_aw_valid_o && m_aw_ready_i) begin
          aw_done_d = 1'b1;
        end
        if (m_w_valid_o && m_w_ready_i) begin
          w_done_d = 1'b1;
        end
        if (aw_done_d && w_done_d) begin
          state_d = WAIT_B;
        end
      end
      WAIT_B: if (m_b_valid_i) state_d = RESP;
      READ:   if (m_ar_ready_i) state_d = WAIT_R;
      WAIT_R: if (m_r_valid_i) state_d = RESP;
      RESP:   if (rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
    end
  end

  // Command and response payload.
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      addr_q  <= cmd_addr_i;
      wdata_q <= cmd_wdata_i;
      wstrb_q <= cmd_wstrb_i;
    end
    // Writes report zero read data.
    if (b_fire) begin
      rdata_q <= '0;
      resp_q  <= m_b_resp_i;
    end else if (r_fire) begin
      rdata_q <= m_r_data_i;
      resp_q  <= m_r_resp_i;
    end
  end

endmodule

// ==== axil_reg_slave.sv ====
`timescale 1ns/10ps

`include "axil_config.svh"

module axil_reg_slave
  import axil_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  s_aw_valid_i,
  output logic  s_aw_ready_o,
  input  addr_t s_aw_addr_i,
  input  logic  s_w_valid_i,
  output logic  s_w_ready_o,
  input  data_t s_w_data_i,
  input  strb_t s_w_strb_i,
  output logic  s_b_valid_o,
  input  logic  s_b_ready_i,
  output resp_t s_b_resp_o,
  input  logic  s_ar_valid_i,
  output logic  s_ar_ready_o,
  input  addr_t s_ar_addr_i,
  output logic  s_r_valid_o,
  input  logic  s_r_ready_i,
  output data_t s_r_data_o,
  output resp_t s_r_resp_o
);

  localparam int    IDX_WIDTH  = $clog2(`AXIL_REG_COUNT);
  localparam int    STRB_WIDTH = $bits(strb_t);
  // First byte address past the bank.
  localparam addr_t ADDR_LIMIT = addr_t'(4 * `AXIL_REG_COUNT);

  data_t                mem_q [`AXIL_REG_COUNT];
  logic                 b_valid_q, r_valid_q;
  resp_t                b_resp_q, r_resp_q;
  data_t                r_data_q;
  logic                 wr_fire, rd_fire;
  logic                 wr_in_range, rd_in_range;
  logic [IDX_WIDTH-1:0] wr_idx, rd_idx;

  // AW and W are taken together, and only with no B outstanding.
  assign s_aw_ready_o = s_aw_valid_i & s_w_valid_i & ~b_valid_q;
  assign s_w_ready_o  = s_aw_ready_o;
  assign s_ar_ready_o = ~r_valid_q;

  assign wr_fire = s_aw_ready_o;
  assign rd_fire = s_ar_valid_i & s_ar_ready_o;

  // Word index is the byte address over four.
  assign wr_idx      = s_aw_addr_i[IDX_WIDTH+1:2];
  assign rd_idx      = s_ar_addr_i[IDX_WIDTH+1:2];
  assign wr_in_range = (s_aw_addr_i < ADDR_LIMIT);
  assign rd_in_range = (s_ar_addr_i < ADDR_LIMIT);

  assign s_b_valid_o = b_valid_q;
  assign s_b_resp_o  = b_resp_q;
  assign s_r_valid_o = r_valid_q;
  assign s_r_data_o  = r_data_q;
  assign s_r_resp_o  = r_resp_q;

  // Register bank, cleared on reset.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_fire && wr_in_range) begin
      // Only strobed bytes change.
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (s_w_strb_i[i]) begin
          mem_q[wr_idx][8*i +: 8] <= s_w_data_i[8*i +: 8];
        end
      end
    end
  end

  // Pending response flags.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (s_b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (s_r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payload.
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      r_data_q <= rd_in_range ? mem_q[rd_idx] : '0;
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

// ==== axil_subsys_top.sv ====
`timescale 1ns/10ps

module axil_subsys_top
  import axil_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  cmd_valid_i,
  output logic  cmd_ready_o,
  input  logic  cmd_write_i,
  input  addr_t cmd_addr_i,
  input  data_t cmd_wdata_i,
  input  strb_t cmd_wstrb_i,
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output resp_t rsp_resp_o
);

  // Master to slice.
  logic  mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready;
  logic  mst_b_valid, mst_b_ready, mst_ar_valid, mst_ar_ready;
  logic  mst_r_valid, mst_r_ready;
  addr_t mst_aw_addr, mst_ar_addr;
  data_t mst_w_data, mst_r_data;
  strb_t mst_w_strb;
  resp_t mst_b_resp, mst_r_resp;

  // Slice to slave.
  logic  slv_aw_valid, slv_aw_ready, slv_w_valid, slv_w_ready;
  logic  slv_b_valid, slv_b_ready, slv_ar_valid, slv_ar_ready;
  logic  slv_r_valid, slv_r_ready;
  addr_t slv_aw_addr, slv_ar_addr;
  data_t slv_w_data, slv_r_data;
  strb_t slv_w_strb;
  resp_t slv_b_resp, slv_r_resp;

  axil_cmd_master i_master (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_write_i  (cmd_write_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_wdata_i  (cmd_wdata_i),
    .cmd_wstrb_i  (cmd_wstrb_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_resp_o   (rsp_resp_o),
    .m_aw_valid_o (mst_aw_valid),
    .m_aw_ready_i (mst_aw_ready),
    .m_aw_addr_o  (mst_aw_addr),
    .m_w_valid_o  (mst_w_valid),
    .m_w_ready_i  (mst_w_ready),
    .m_w_data_o   (mst_w_data),
    .m_w_strb_o   (mst_w_strb),
    .m_b_valid_i  (mst_b_valid),
    .m_b_ready_o  (mst_b_ready),
    .m_b_resp_i   (mst_b_resp),
    .m_ar_valid_o (mst_ar_valid),
    .m_ar_ready_i (mst_ar_ready),
    .m_ar_addr_o  (mst_ar_addr),
    .m_r_valid_i  (mst_r_valid),
    .m_r_ready_o  (mst_r_ready),
    .m_r_data_i   (mst_r_data),
    .m_r_resp_i   (mst_r_resp)
  );

  // Full register cut on all five channels.
  axil_slice i_slice (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_aw_valid_i (mst_aw_valid),
    .s_aw_ready_o (mst_aw_ready),
    .s_aw_addr_i  (mst_aw_addr),
    .s_w_valid_i  (mst_w_valid),
    .s_w_ready_o  (mst_w_ready),
    .s_w_data_i   (mst_w_data),
    .s_w_strb_i   (mst_w_strb),
    .s_b_valid_o  (mst_b_valid),
    .s_b_ready_i  (mst_b_ready),
    .s_b_resp_o   (mst_b_resp),
    .s_ar_valid_i (mst_ar_valid),
    .s_ar_ready_o (mst_ar_ready),
    .s_ar_addr_i  (mst_ar_addr),
    .s_r_valid_o  (mst_r_valid),
    .s_r_ready_i  (mst_r_ready),
    .s_r_data_o   (mst_r_data),
    .s_r_resp_o   (mst_r_resp),
    .m_aw_valid_o (slv_aw_valid),
    .m_aw_ready_i (slv_aw_ready),
    .m_aw_addr_o  (slv_aw_addr),
    .m_w_valid_o  (slv_w_valid),
    .m_w_ready_i  (slv_w_ready),
    .m_w_data_o   (slv_w_data),
    .m_w_strb_o   (slv_w_strb),
    .m_b_valid_i  (slv_b_valid),
    .m_b_ready_o  (slv_b_ready),
    .m_b_resp_i   (slv_b_resp),
    .m_ar_valid_o (slv_ar_valid),
    .m_ar_ready_i (slv_ar_ready),
    .m_ar_addr_o  (slv_ar_addr),
    .m_r_valid_i  (slv_r_valid),
    .m_r_ready_o  (slv_r_ready),
    .m_r_data_i   (slv_r_data),
    .m_r_resp_i   (slv_r_resp)
  );

  axil_reg_slave i_slave (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_aw_valid_i (slv_aw_valid),
    .s_aw_ready_o (slv_aw_ready),
    .s_aw_addr_i  (slv_aw_addr),
    .s_w_valid_i  (slv_w_valid),
    .s_w_ready_o  (slv_w_ready),
    .s_w_data_i   (slv_w_data),
    .s_w_strb_i   (slv_w_strb),
    .s_b_valid_o  (slv_b_valid),
    .s_b_ready_i  (slv_b_ready),
    .s_b_resp_o   (slv_b_resp),
    .s_ar_valid_i (slv_ar_valid),
    .s_ar_ready_o (slv_ar_ready),
    .s_ar_addr_i  (slv_ar_addr),
    .s_r_valid_o  (slv_r_valid),
    .s_r_ready_i  (slv_r_ready),
    .s_r_data_o   (slv_r_data),
    .s_r_resp_o   (slv_r_resp)
  );

endmodule

// ==== axil_subsys_sva.sv ====
`timescale 1ns/10ps

module axil_slice_sva
  import axil_pkg::*;
(
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  m_aw_valid_i,
  input logic  m_aw_ready_i,
  input addr_t m_aw_addr_i,
  input logic  m_w_valid_i,
  input logic  m_w_ready_i,
  input data_t m_w_data_i,
  input strb_t m_w_strb_i,
  input logic  m_ar_valid_i,
  input logic  s_r_valid_i,
  input logic  s_r_ready_i,
  input data_t s_r_data_i,
  input resp_t s_r_resp_i
);

  // Master-side valids stay low while reset is held.
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !(m_aw_valid_i || m_w_valid_i || m_ar_valid_i))
    else $error("Slice master-side valid high during reset");

  // A stalled AW beat keeps valid and address.
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_aw_valid_i && !m_aw_ready_i) |=> (m_aw_valid_i && $stable(m_aw_addr_i)))
    else $error("Slice AW beat dropped or changed while stalled");

  // A stalled W beat keeps valid, data and strobe.
  w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_w_valid_i && !m_w_ready_i) |=>
    (m_w_valid_i && $stable(m_w_data_i) && $stable(m_w_strb_i)))
    else $error("Slice W beat dropped or changed while stalled");

  // A stalled R beat toward the master keeps data and resp.
  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_r_valid_i && !s_r_ready_i) |=>
    (s_r_valid_i && $stable(s_r_data_i) && $stable(s_r_resp_i)))
    else $error("Slice R beat dropped or changed while stalled");

endmodule

bind axil_slice axil_slice_sva i_slice_sva (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .m_aw_valid_i (m_aw_valid_o),
  .m_aw_ready_i (m_aw_ready_i),
  .m_aw_addr_i  (m_aw_addr_o),
  .m_w_valid_i  (m_w_valid_o),
  .m_w_ready_i  (m_w_ready_i),
  .m_w_data_i   (m_w_data_o),
  .m_w_strb_i   (m_w_strb_o),
  .m_ar_valid_i (m_ar_valid_o),
  .s_r_valid_i  (s_r_valid_o),
  .s_r_ready_i  (s_r_ready_i),
  .s_r_data_i   (s_r_data_o),
  .s_r_resp_i   (s_r_resp_o)
);

// ==== tb_axil_subsys.sv ====
`timescale 1ns/10ps

`include "axil_config.svh"

module tb_axil_subsys
  import axil_pkg::*;
();

  // Directed part is 16 + 32 + 32 + 8 + 16 commands.
  localparam int DIRECTED_CMDS  = 104;
  localparam int RANDOM_CMDS    = 400;
  localparam int TIMEOUT_CYCLES = (DIRECTED_CMDS + RANDOM_CMDS) * 25;
  localparam int BYTES          = `AXIL_DATA_WIDTH / 8;
  // AXI response encodings.
  localparam resp_t EXP_OKAY    = 2'b00;
  localparam resp_t EXP_SLVERR  = 2'b10;
  // Addresses at or past the end of the bank.
  localparam addr_t OOR_ADDR [4] = '{12'd64, 12'd68, 12'd252, 12'hFFC};

  logic  clk_i, rst_n_i;
  logic  cmd_valid_i, cmd_ready_o, cmd_write_i;
  addr_t cmd_addr_i;
  data_t cmd_wdata_i;
  strb_t cmd_wstrb_i;
  logic  rsp_valid_o, rsp_ready_i;
  data_t rsp_rdata_o;
  resp_t rsp_resp_o;

  data_t model_mem [`AXIL_REG_COUNT];
  data_t exp_rdata_q [$];
  resp_t exp_resp_q [$];
  int    cycle_count;

  axil_subsys_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic fail_run();
    $display("Checks failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  // Expected response for one command; the model follows writes.
  function automatic resp_t ref_model(input logic write, input addr_t addr,
      input data_t wdata, input strb_t wstrb, inout data_t model [`AXIL_REG_COUNT],
      output data_t rdata);
    int idx;
    idx   = int'(addr) / 4;
    rdata = '0;
    // Beyond the bank, nothing changes and reads give zero.
    if (int'(addr) >= 4 * `AXIL_REG_COUNT) begin
      return EXP_SLVERR;
    end
    if (write) begin
      for (int b = 0; b < BYTES; b++) begin
        if (wstrb[b]) begin
          model[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end else begin
      rdata = model[idx];
    end
    return EXP_OKAY;
  endfunction

  // Queues the expectation, then holds the command until it transfers.
  task automatic send_cmd(input logic write, input addr_t addr, input data_t wdata,
      input strb_t wstrb);
    data_t exp_rdata;
    resp_t exp_resp;
    exp_resp = ref_model(write, addr, wdata, wstrb, model_mem, exp_rdata);
    exp_rdata_q.push_back(exp_rdata);
    exp_resp_q.push_back(exp_resp);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_write_i <= write;
    cmd_addr_i  <= addr;
    cmd_wdata_i <= wdata;
    cmd_wstrb_i <= wstrb;
    do begin
      @(posedge clk_i);
    end while (!cmd_ready_o);
    cmd_valid_i <= 1'b0;
  endtask

  initial begin : stimulus
    logic  wr;
    addr_t addr;
    void'($urandom(71));
    for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
      model_mem[i] = '0;
    end
    rst_n_i     = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_write_i = 1'b0;
    cmd_addr_i  = '0;
    cmd_wdata_i = '0;
    cmd_wstrb_i = '0;
    rsp_ready_i = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    assert (cmd_ready_o && !rsp_valid_o)
      else begin
        $display("Master not idle with an empty response port after reset");
        fail_run();
      end
    // Random back-pressure on the response port.
    fork
      forever begin
        @(posedge clk_i);
        rsp_ready_i <= (($urandom % 4) != 0);
      end
    join_none
    // Bank reads as zero after reset.
    for (int i = 0; i < `AXIL_REG_COUNT; i++) send_cmd(1'b0, addr_t'(i * 4), '0, '0);
    // Full-word writes, then readback.
    for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
      send_cmd(1'b1, addr_t'(i * 4), data_t'($urandom), '1);
    end
    for (int i = 0; i < `AXIL_REG_COUNT; i++) send_cmd(1'b0, addr_t'(i * 4), '0, '0);
    // Partial writes with random strobes.
    for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
      send_cmd(1'b1, addr_t'(i * 4), data_t'($urandom), strb_t'($urandom));
    end
    for (int i = 0; i < `AXIL_REG_COUNT; i++) send_cmd(1'b0, addr_t'(i * 4), '0, '0);
    // Out-of-range writes and reads, then a full readback.
    for (int i = 0; i < 4; i++) send_cmd(1'b1, OOR_ADDR[i], data_t'($urandom), '1);
    for (int i = 0; i < 4; i++) send_cmd(1'b0, OOR_ADDR[i], '0, '0);
    for (int i = 0; i < `AXIL_REG_COUNT; i++) send_cmd(1'b0, addr_t'(i * 4), '0, '0);
    // Random mix, mostly near the bank with a few far addresses.
    for (int n = 0; n < RANDOM_CMDS; n++) begin
      wr   = $urandom_range(0, 1);
      addr = (($urandom % 16) == 0) ? addr_t'($urandom) : addr_t'($urandom_range(0, 19) * 4);
      send_cmd(wr, addr, data_t'($urandom), strb_t'($urandom));
    end
    while (exp_resp_q.size() != 0) @(posedge clk_i);
    // Drain a little longer so a stray response would show up.
    repeat (20) @(posedge clk_i);
    $display("All checks passed");
    $finish;
  end

  // Compares every transferred response in issue order.
  initial begin : compare
    data_t exp_rdata;
    resp_t exp_resp;
    forever begin
      @(posedge clk_i);
      if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
        assert (exp_resp_q.size() != 0)
          else begin
            $display("Response at %0t with no command outstanding", $time);
            fail_run();
          end
        exp_rdata = exp_rdata_q.pop_front();
        exp_resp  = exp_resp_q.pop_front();
        assert (rsp_rdata_o == exp_rdata)
          else begin
            $display("Mismatch at %0t: rsp_rdata_o expected 0x%08h, actual 0x%08h",
                     $time, exp_rdata, rsp_rdata_o);
            fail_run();
          end
        assert (rsp_resp_o == exp_resp)
          else begin
            $display("Mismatch at %0t: rsp_resp_o expected %0d, actual %0d",
                     $time, exp_resp, rsp_resp_o);
            fail_run();
          end
      end
    end
  end

  // Cycle limit from the total command count.
  initial begin : watchdog
    cycle_count = 0;
    forever begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Run timed out after %0d cycles", cycle_count);
        fail_run();
      end
    end
  end

endmodule

// ==== build.f ====
+incdir+.
axil_pkg.sv
axil_spill_register.sv
axil_slice.sv
axil_cmd_master.sv
axil_reg_slave.sv
axil_subsys_top.sv
axil_subsys_sva.sv
tb_axil_subsys.sv

// ==== Bender.yml ====
package:
  name: axil_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axil_pkg.sv
      - axil_spill_register.sv
      - axil_slice.sv
      - axil_cmd_master.sv
      - axil_reg_slave.sv
      - axil_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - axil_subsys_sva.sv
      - tb_axil_subsys.sv
